// File: src/pe_pkg.sv
//////////////////////////////
// shared widths and opcodes
//////////////////////////////

package pe_pkg;

    // one real or imaginary part, two's complement
    localparam int DATA_W = 16;

    // packed complex sample
    // real part in the upper half, imaginary in the lower
    localparam int CPLX_W = 2 * DATA_W;

    // twiddle table size
    localparam int COEF_DEPTH = 16;

    // address width follows the table depth
    localparam int COEF_ADDR_W = $clog2(COEF_DEPTH);

    // pe instruction opcodes
    // OP_ADD    a + b
    // OP_CMUL   a * b
    // OP_MULADD a + b * w
    // OP_MULSUB a - b * w
    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_CMUL   = 2'd1,
        OP_MULADD = 2'd2,
        OP_MULSUB = 2'd3
    } pe_op_t;

endpackage

// File: src/twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [pe_pkg::COEF_ADDR_W-1:0] addr,
    output logic [pe_pkg::CPLX_W-1:0]      data
);
    import pe_pkg::*;

    logic [CPLX_W-1:0] entry;

    //////////////////////////////
    // twiddle table
    //////////////////////////////

    // {cos, -sin} of 2*pi*k/16 in Q1.14
    // +1.0 clipped to 16383
    always_comb begin
        case (addr)
            4'd0:    entry = 32'h3FFF_0000;
            4'd1:    entry = 32'h3B21_E782;
            4'd2:    entry = 32'h2D41_D2BF;
            4'd3:    entry = 32'h187E_C4DF;
            // -j
            4'd4:    entry = 32'h0000_C000;
            4'd5:    entry = 32'hE782_C4DF;
            4'd6:    entry = 32'hD2BF_D2BF;
            4'd7:    entry = 32'hC4DF_E782;
            // -1
            4'd8:    entry = 32'hC000_0000;
            4'd9:    entry = 32'hC4DF_187E;
            4'd10:   entry = 32'hD2BF_2D41;
            4'd11:   entry = 32'hE782_3B21;
            // +j, clipped
            4'd12:   entry = 32'h0000_3FFF;
            4'd13:   entry = 32'h187E_3B21;
            4'd14:   entry = 32'h2D41_2D41;
            default: entry = 32'h3B21_187E;
        endcase
    end

    // one cycle read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= '0;
        end else begin
            data <= entry;
        end
    end

endmodule

// File: src/coef_arbiter.sv
`timescale 1ns/1ps

module coef_arbiter #(
    parameter int NUM_REQ = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [NUM_REQ-1:0]                     req,
    input  logic [NUM_REQ*pe_pkg::COEF_ADDR_W-1:0] addr,
    input  logic [pe_pkg::CPLX_W-1:0]              rom_data,
    output logic [NUM_REQ-1:0]                     gnt,
    output logic [NUM_REQ-1:0]                     rvalid,
    output logic [pe_pkg::COEF_ADDR_W-1:0]         rom_addr,
    output logic [pe_pkg::CPLX_W-1:0]              data
);
    import pe_pkg::*;

    localparam int IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] win_idx;
    logic             win_v;
    logic [IDX_W-1:0] rd_idx_q;
    logic             rd_v_q;

    //////////////////////////////
    // round-robin pick
    //////////////////////////////

    // scan upward from the pointer, first requester wins
    always_comb begin
        int idx;
        win_v   = 1'b0;
        win_idx = ptr_q;
        for (int i = 0; i < NUM_REQ; i++) begin
            idx = (int'(ptr_q) + i) % NUM_REQ;
            if (!win_v && req[idx]) begin
                win_v   = 1'b1;
                win_idx = IDX_W'(idx);
            end
        end
    end

    // one-hot grant, at most one per cycle
    always_comb begin
        gnt = '0;
        if (win_v) begin
            gnt[win_idx] = 1'b1;
        end
    end

    // winner's address straight to the rom
    assign rom_addr = addr[win_idx*COEF_ADDR_W +: COEF_ADDR_W];

    //////////////////////////////
    // pointer and return path
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q    <= '0;
            rd_v_q   <= 1'b0;
            rd_idx_q <= '0;
        end else begin
            // priority to the one after the winner
            if (win_v) begin
                ptr_q <= (win_idx == IDX_W'(NUM_REQ - 1)) ? '0 : win_idx + 1'b1;
            end
            // rom data lands next cycle, remember who asked
            rd_v_q   <= win_v;
            rd_idx_q <= win_idx;
        end
    end

    always_comb begin
        rvalid = '0;
        if (rd_v_q) begin
            rvalid[rd_idx_q] = 1'b1;
        end
    end

    // broadcast, rvalid picks the taker
    assign data = rom_data;

endmodule

// File: src/cmplx_mac.sv
`timescale 1ns/1ps

module cmplx_mac #(
    parameter int FRAC_BITS = 14
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_v,
    input  pe_pkg::pe_op_t            op,
    input  logic [pe_pkg::CPLX_W-1:0] a,
    input  logic [pe_pkg::CPLX_W-1:0] b,
    input  logic [pe_pkg::CPLX_W-1:0] w,
    output logic                      out_v,
    output logic [pe_pkg::CPLX_W-1:0] result
);
    import pe_pkg::*;

    // full product sum needs one bit of growth
    localparam int PROD_W = 2 * DATA_W + 1;

    logic signed [DATA_W-1:0] x_re, x_im;
    logic signed [DATA_W-1:0] b_re, b_im;
    logic signed [PROD_W-1:0] p_re_full, p_im_full;
    logic signed [PROD_W-1:0] p_re_sh, p_im_sh;
    logic signed [DATA_W-1:0] p_re_d, p_im_d;

    // stage 1 registers
    logic                     v1_q;
    pe_op_t                   op1_q;
    logic        [CPLX_W-1:0] a1_q;
    logic signed [DATA_W-1:0] p_re_q, p_im_q;

    // stage 2 combinational sum
    logic signed [DATA_W-1:0] a_re, a_im;
    logic signed [DATA_W-1:0] s_re, s_im;

    //////////////////////////////
    // stage 1: products
    //////////////////////////////

    always_comb begin
        // a*b for cmul, b*w otherwise
        x_re = (op == OP_CMUL) ? a[CPLX_W-1:DATA_W] : w[CPLX_W-1:DATA_W];
        x_im = (op == OP_CMUL) ? a[DATA_W-1:0] : w[DATA_W-1:0];
        b_re = b[CPLX_W-1:DATA_W];
        b_im = b[DATA_W-1:0];
        // operands sign-extend to PROD_W before multiply
        p_re_full = x_re * b_re - x_im * b_im;
        p_im_full = x_re * b_im + x_im * b_re;
        p_re_sh   = p_re_full >>> FRAC_BITS;
        p_im_sh   = p_im_full >>> FRAC_BITS;
        // add passes b untouched
        if (op == OP_ADD) begin
            p_re_d = b_re;
            p_im_d = b_im;
        end else begin
            p_re_d = p_re_sh[DATA_W-1:0];
            p_im_d = p_im_sh[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        op1_q  <= op;
        a1_q   <= a;
        p_re_q <= p_re_d;
        p_im_q <= p_im_d;
    end

    //////////////////////////////
    // stage 2: accumulate
    //////////////////////////////

    always_comb begin
        a_re = a1_q[CPLX_W-1:DATA_W];
        a_im = a1_q[DATA_W-1:0];
        // sums wrap at DATA_W
        case (op1_q)
            OP_MULSUB: begin
                s_re = a_re - p_re_q;
                s_im = a_im - p_im_q;
            end
            OP_CMUL: begin
                s_re = p_re_q;
                s_im = p_im_q;
            end
            default: begin
                s_re = a_re + p_re_q;
                s_im = a_im + p_im_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        result <= {s_re, s_im};
    end

    // valid pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q  <= 1'b0;
            out_v <= 1'b0;
        end else begin
            v1_q  <= in_v;
            out_v <= v1_q;
        end
    end

endmodule

// File: src/pe.sv
`timescale 1ns/1ps

module pe #(
    parameter int FRAC_BITS = 14
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           din_v,
    input  logic [pe_pkg::CPLX_W-1:0]      din,
    input  logic                           shift_in_v,
    input  pe_pkg::pe_op_t                 shift_in_op,
    input  logic [pe_pkg::COEF_ADDR_W-1:0] shift_in_coef,
    input  logic                           coef_gnt,
    input  logic                           coef_rvalid,
    input  logic [pe_pkg::CPLX_W-1:0]      coef_data,
    output logic                           dout_v,
    output logic [pe_pkg::CPLX_W-1:0]      dout,
    output logic                           shift_out_v,
    output pe_pkg::pe_op_t                 shift_out_op,
    output logic [pe_pkg::COEF_ADDR_W-1:0] shift_out_coef,
    output logic                           coef_req,
    output logic [pe_pkg::COEF_ADDR_W-1:0] coef_addr,
    output logic                           ready
);
    import pe_pkg::*;

    // held instruction
    pe_op_t                 op_q;
    logic [COEF_ADDR_W-1:0] coef_idx_q;

    // coefficient fetch state
    logic                   req_q;
    logic                   granted_q;
    logic                   ready_q;
    logic [CPLX_W-1:0]      w_q;

    // sample pairing
    logic                   phase_q;
    logic [CPLX_W-1:0]      a_q;

    logic                   need_coef;
    logic                   coef_take;
    logic                   pair_v;

    // only the multiply-accumulate ops read the rom
    assign need_coef = (shift_in_op == OP_MULADD) || (shift_in_op == OP_MULSUB);

    // return counts only if granted since the latest load
    assign coef_take = coef_rvalid && granted_q && !shift_in_v;

    // phase high means this sample is b
    assign pair_v = din_v && phase_q;

    //////////////////////////////
    // instruction and fetch
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q        <= OP_ADD;
            coef_idx_q  <= '0;
            shift_out_v <= 1'b0;
            req_q       <= 1'b0;
            granted_q   <= 1'b0;
            ready_q     <= 1'b1;
            phase_q     <= 1'b0;
        end else begin
            // old instruction leaves as the new one lands
            shift_out_v <= shift_in_v;
            if (shift_in_v) begin
                op_q       <= shift_in_op;
                coef_idx_q <= shift_in_coef;
                // a grant in this cycle is lost, request again
                req_q      <= need_coef;
                granted_q  <= 1'b0;
                ready_q    <= !need_coef;
                // pairing restarts at a
                phase_q    <= 1'b0;
            end else begin
                if (din_v) begin
                    phase_q <= ~phase_q;
                end
                if (req_q && coef_gnt) begin
                    req_q     <= 1'b0;
                    granted_q <= 1'b1;
                end
                if (coef_take) begin
                    granted_q <= 1'b0;
                    ready_q   <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // payload registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (shift_in_v) begin
            shift_out_op   <= op_q;
            shift_out_coef <= coef_idx_q;
        end
        if (coef_take) begin
            w_q <= coef_data;
        end
        // first of the pair waits here
        if (din_v && !phase_q) begin
            a_q <= din;
        end
    end

    assign coef_req  = req_q;
    assign coef_addr = coef_idx_q;
    assign ready     = ready_q;

    //////////////////////////////
    // datapath
    //////////////////////////////

    // b goes in straight from din, a from the register
    cmplx_mac #(
        .FRAC_BITS (FRAC_BITS)
    ) u_mac (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_v   (pair_v),
        .op     (op_q),
        .a      (a_q),
        .b      (din),
        .w      (w_q),
        .out_v  (dout_v),
        .result (dout)
    );

endmodule

// File: src/pe_array.sv
`timescale 1ns/1ps

module pe_array #(
    parameter int FRAC_BITS = 14,
    parameter int NUM_REQ   = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           din_v,
    input  logic [pe_pkg::CPLX_W-1:0]      din,
    input  logic                           inst_v,
    input  pe_pkg::pe_op_t                 inst_op,
    input  logic [pe_pkg::COEF_ADDR_W-1:0] inst_coef,
    output logic                           dout_v,
    output logic [pe_pkg::CPLX_W-1:0]      dout,
    output logic                           ready0,
    output logic                           ready1
);
    import pe_pkg::*;

    // pe0 to pe1 instruction chain
    logic                         sh_v;
    pe_op_t                       sh_op;
    logic [COEF_ADDR_W-1:0]       sh_coef;

    // pe0 results feed pe1 samples
    logic                         mid_v;
    logic [CPLX_W-1:0]            mid;

    // shared coefficient bus, index k is pe k
    logic [NUM_REQ-1:0]             coef_req;
    logic [NUM_REQ-1:0]             coef_gnt;
    logic [NUM_REQ-1:0]             coef_rvalid;
    logic [NUM_REQ*COEF_ADDR_W-1:0] coef_addr;
    logic [CPLX_W-1:0]              coef_data;
    logic [COEF_ADDR_W-1:0]         rom_addr;
    logic [CPLX_W-1:0]              rom_data;

    //////////////////////////////
    // processing elements
    //////////////////////////////

    pe #(
        .FRAC_BITS (FRAC_BITS)
    ) u_pe0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .din_v          (din_v),
        .din            (din),
        .shift_in_v     (inst_v),
        .shift_in_op    (inst_op),
        .shift_in_coef  (inst_coef),
        .coef_gnt       (coef_gnt[0]),
        .coef_rvalid    (coef_rvalid[0]),
        .coef_data      (coef_data),
        .dout_v         (mid_v),
        .dout           (mid),
        .shift_out_v    (sh_v),
        .shift_out_op   (sh_op),
        .shift_out_coef (sh_coef),
        .coef_req       (coef_req[0]),
        .coef_addr      (coef_addr[0 +: COEF_ADDR_W]),
        .ready          (ready0)
    );

    // end of the chain, its shift outputs go nowhere
    pe #(
        .FRAC_BITS (FRAC_BITS)
    ) u_pe1 (
        .clk            (clk),
        .rst_n          (rst_n),
        .din_v          (mid_v),
        .din            (mid),
        .shift_in_v     (sh_v),
        .shift_in_op    (sh_op),
        .shift_in_coef  (sh_coef),
        .coef_gnt       (coef_gnt[1]),
        .coef_rvalid    (coef_rvalid[1]),
        .coef_data      (coef_data),
        .dout_v         (dout_v),
        .dout           (dout),
        .shift_out_v    (),
        .shift_out_op   (),
        .shift_out_coef (),
        .coef_req       (coef_req[1]),
        .coef_addr      (coef_addr[COEF_ADDR_W +: COEF_ADDR_W]),
        .ready          (ready1)
    );

    //////////////////////////////
    // twiddle fetch
    //////////////////////////////

    coef_arbiter #(
        .NUM_REQ (NUM_REQ)
    ) u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (coef_req),
        .addr     (coef_addr),
        .rom_data (rom_data),
        .gnt      (coef_gnt),
        .rvalid   (coef_rvalid),
        .rom_addr (rom_addr),
        .data     (coef_data)
    );

    twiddle_rom u_rom (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (rom_addr),
        .data  (rom_data)
    );

endmodule

// File: test/tb_pe_array.sv
`timescale 1ns/1ps

module tb_pe_array;
    import pe_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   din_v;
    logic [CPLX_W-1:0]      din;
    logic                   inst_v;
    pe_op_t                 inst_op;
    logic [COEF_ADDR_W-1:0] inst_coef;
    logic                   dout_v;
    logic [CPLX_W-1:0]      dout;
    logic                   ready0;
    logic                   ready1;

    // expected results, oldest first
    logic [CPLX_W-1:0] exp_q[$];

    int cyc = 0;
    int seed = 51;
    int n_lines = 0;
    // pending latency check
    bit lat_armed = 1'b0;
    int lat_ref;
    int lat_n;

    pe_array #(
        .FRAC_BITS (14),
        .NUM_REQ   (2)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .din_v     (din_v),
        .din       (din),
        .inst_v    (inst_v),
        .inst_op   (inst_op),
        .inst_coef (inst_coef),
        .dout_v    (dout_v),
        .dout      (dout),
        .ready0    (ready0),
        .ready1    (ready1)
    );

    always #5 clk = ~clk;

    // posedge count, stable at negedge
    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abort(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // real in the upper half
    function automatic logic [CPLX_W-1:0] to_cplx(input int re, input int im);
        return {re[DATA_W-1:0], im[DATA_W-1:0]};
    endfunction

    // one clock of input values
    task automatic step(input logic dv, input logic [CPLX_W-1:0] d, input logic iv,
                        input pe_op_t op, input logic [COEF_ADDR_W-1:0] coef);
        @(posedge clk);
        din_v     <= dv;
        din       <= d;
        inst_v    <= iv;
        inst_op   <= op;
        inst_coef <= coef;
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, OP_ADD, '0);
    endtask

    // two idles let a load reach pe1 first
    task automatic wait_ready();
        idle();
        idle();
        @(negedge clk);
        while (!(ready0 && ready1)) begin
            idle();
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // result monitor
    //////////////////////////////

    always @(negedge clk) begin
        if (rst_n && dout_v) begin
            if (exp_q.size() == 0) begin
                abort($sformatf("unexpected result %h at %0t, none was expected", dout, $time));
            end else begin
                check("dout", dout, exp_q.pop_front());
                // latency counts from the edge that drove the last sample
                if (lat_armed && cyc > lat_ref) begin
                    lat_armed = 1'b0;
                    check("latency", cyc - lat_ref, lat_n);
                end
            end
        end
    end

    // 20 cycles per line of the test file
    initial begin
        wait (n_lines > 0);
        repeat (20 * n_lines) @(posedge clk);
        abort($sformatf("timeout: the run did not finish within %0d cycles", 20 * n_lines));
    end

    //////////////////////////////
    // command interpreter
    //////////////////////////////

    task automatic run_commands(input int fd, output bit bad);
        int         code;
        int         c;
        int         x;
        int         y;
        int         gap;
        logic [7:0] cmd;
        bad  = 1'b0;
        code = $fscanf(fd, " %c", cmd);
        while (code == 1 && !bad) begin
            case (cmd)
                "#": begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "I": begin
                    code = $fscanf(fd, "%d %d", x, y);
                    step(1'b0, '0, 1'b1, pe_op_t'(x), COEF_ADDR_W'(y));
                end
                "W": wait_ready();
                "D": begin
                    code = $fscanf(fd, "%d %d", x, y);
                    step(1'b1, to_cplx(x, y), 1'b0, OP_ADD, '0);
                end
                "E": begin
                    code = $fscanf(fd, "%d %d", x, y);
                    exp_q.push_back(to_cplx(x, y));
                end
                "G": begin
                    code = $fscanf(fd, "%d", x);
                    repeat (x) idle();
                end
                // random idle, 0 to max cycles
                "R": begin
                    code = $fscanf(fd, "%d", x);
                    gap  = $unsigned($random(seed)) % (x + 1);
                    repeat (gap) idle();
                end
                "L": begin
                    code = $fscanf(fd, "%d", x);
                    @(negedge clk);
                    lat_ref   = cyc;
                    lat_n     = x;
                    lat_armed = 1'b1;
                end
                default: bad = 1'b1;
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
    endtask

    // drain what is still in flight, then decide
    task automatic finish_run();
        int waited;
        waited = 0;
        idle();
        while (exp_q.size() != 0 && waited < 16) begin
            idle();
            waited++;
        end
        repeat (4) idle();
        @(negedge clk);
        if (exp_q.size() != 0) begin
            abort($sformatf("%0d expected results never appeared", exp_q.size()));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    endtask

    initial begin
        int fd;
        int c;
        int lines;
        bit bad;
        clk       = 1'b0;
        rst_n     = 1'b0;
        din_v     = 1'b0;
        din       = '0;
        inst_v    = 1'b0;
        inst_op   = OP_ADD;
        inst_coef = '0;
        fd = $fopen("test/pe_array_tests.txt", "r");
        if (fd == 0) begin
            abort("could not open test/pe_array_tests.txt");
        end else begin
            // first pass only sizes the watchdog
            lines = 1;
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10) begin
                    lines++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            n_lines = lines;
            fd = $fopen("test/pe_array_tests.txt", "r");
            repeat (2) @(posedge clk);
            rst_n <= 1'b1;
            // reset state
            @(negedge clk);
            check("ready0", ready0, 1);
            check("ready1", ready1, 1);
            check("dout_v", dout_v, 0);
            run_commands(fd, bad);
            $fclose(fd);
            if (bad) begin
                abort("unknown command in test/pe_array_tests.txt");
            end else begin
                finish_run();
            end
        end
    end

endmodule

// File: build.f
src/pe_pkg.sv
src/twiddle_rom.sv
src/coef_arbiter.sv
src/cmplx_mac.sv
src/pe.sv
src/pe_array.sv
test/tb_pe_array.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, then run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_pe_array \
        -f build.f -o sim_pe_array \
    && ./obj_dir/sim_pe_array \
    || exit 1

// File: test/pe_array_tests.txt
# cmd args: I op coef | W | D re im | E re im | G n | L n | R max (random idle 0..max)
# op 0 add, 1 cmul, 2 muladd, 3 mulsub; re and im are signed decimal
# idle after reset, both pes hold add
G 4
# add chain with fixed latency, then back-to-back groups
D 1 2 D 3 4 D 5 6 D 7 8 L 4 E 16 20
D -100 50 D 200 -25 D -1 -1 D 1000 3 E 1099 27
D 0 0 D 0 0 D 0 0 D 0 0 E 0 0
G 6
D 10 -10 D 20 -20 D 30 -30 D 40 -40 L 4 E 100 -100
G 4
# pe1 cmul, pe0 add, pe1 loaded first
I 1 0
I 0 0
W
D 8192 0 D 8192 0 D 1000 2000 D 234 -500 E 1234 1500
D 1000 1000 D 2000 3000 D -6000 500 D 1000 2000 E -1526 -763
D -10 1 D 3 2 D 4000 -1000 D 1000 -5000 E -2 3
G 6
# shared rom, pe1 mulsub with twiddle 2, pe0 muladd with twiddle 4
I 3 2
I 2 4
W
D 100 200 D 300 -50 D -400 120 D 60 500 E -63 -71
D 1000 -2000 D -1500 700 D 2500 0 D -300 -800 E 286 490
G 6
# back to add, unbroken stream
I 0 0
I 0 0
W
D 11 22 D 33 44 D 55 66 D 77 88 E 176 220
D -5 9 D 12 -7 D 40 1 D -3 100 E 44 103
G 4
# same samples with random gaps
D 11 22 R 4 D 33 44 R 4 D 55 66 R 4 D 77 88 E 176 220
R 4 D -5 9 R 4 D 12 -7 R 4 D 40 1 R 4 D -3 100 E 44 103
G 6
# three samples then a reload, no result for them
D 9 9 D 8 8 D 7 7
I 0 0
W
D 2 3 D 4 5 D 6 7 D 8 9 L 4 E 20 24
G 6
# sums wrap at 16 bits
D 30000 -30000 D 10000 -10000 D 20000 -20000 D 5000 -5000 E -536 536
D 32767 -32768 D 1 -1 D 0 0 D 0 0 E -32768 32767
G 4
